// File: src/gsau_pkg.sv
`default_nettype none

package gsau_pkg;

  // vector geometry
  // lanes double as array columns and pipeline stages
  localparam int LANES = 4;

  // one signed lane, products and sums wrap here
  localparam int LANE_W = 16;

  // destination register number
  localparam int VDST_W = 8;

  // outstanding input instructions, acceptance to writeback
  localparam int DEST_DEPTH = 8;

  // weight row pointer, covers LANES rows
  localparam int ROW_W = 2;

  // single lane value, read as signed
  typedef logic [LANE_W-1:0] lane_t;

  // whole operand or result
  // lane 0 sits in the low bits
  typedef logic [LANES*LANE_W-1:0] vec_t;

  // destination register number
  typedef logic [VDST_W-1:0] vdst_t;

endpackage

`default_nettype wire

// File: src/gsau_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             i_wr,
  input  wire logic             i_rd,
  input  wire logic [WIDTH-1:0] i_din,
  output logic      [WIDTH-1:0] o_dout,
  output logic                  o_empty,
  output logic                  o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // ignore writes when full and reads when empty
  assign do_wr = i_wr && !o_full;
  assign do_rd = i_rd && !o_empty;

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));

  // first-word fall-through shows the head
  assign o_dout = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_din;
    end
  end

  // pointers wrap at DEPTH
  // depth need not be a power of two
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // read and write together leave the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/gsau_issue.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_issue (
  input  wire logic           CLK,
  input  wire logic           nRST,
  // scoreboard instruction
  input  wire logic           i_sb_nvalid,
  input  wire gsau_pkg::vdst_t i_sb_nvdst,
  input  wire logic           i_sb_weight,
  // register file operand
  input  wire logic           i_veg_valid,
  input  wire gsau_pkg::vec_t i_veg_vdata,
  // back-pressure sources
  input  wire logic           i_dest_full,
  input  wire logic           i_busy,
  // ready levels
  output logic                o_sb_ready,
  output logic                o_veg_ready,
  // scoreboard notification
  output logic                o_sb_valid,
  output gsau_pkg::vdst_t     o_sb_vdst,
  // array side
  output gsau_pkg::vec_t      o_sa_array_in,
  output logic                o_sa_input_en,
  output logic                o_sa_weight_en,
  // destination fifo push
  output logic                o_dest_push,
  output gsau_pkg::vdst_t     o_dest_din
);

  logic accept;

  // room for another destination
  assign o_sb_ready = !i_dest_full;

  // weight loads wait for the array to drain
  // so in-flight inputs keep their weights
  assign o_veg_ready = o_sb_ready && (!i_sb_weight || !i_busy);

  // all four levels high on the edge
  assign accept = i_sb_nvalid && i_veg_valid && o_sb_ready && o_veg_ready;

  // steer operand by the weight flag
  assign o_sa_weight_en = accept && i_sb_weight;
  assign o_sa_input_en  = accept && !i_sb_weight;
  assign o_sa_array_in  = accept ? i_veg_vdata : '0;

  // only inputs hold a destination slot
  assign o_dest_push = o_sa_input_en;
  assign o_dest_din  = i_sb_nvdst;

  // notify one cycle after acceptance
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      o_sb_valid <= 1'b0;
    end else begin
      o_sb_valid <= accept;
    end
  end

  // capture the accepted destination for the notify pulse
  always_ff @(posedge CLK) begin
    if (accept) begin
      o_sb_vdst <= i_sb_nvdst;
    end
  end

endmodule

`default_nettype wire

// File: src/gsau_array.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_array (
  input  wire logic           CLK,
  input  wire logic           nRST,
  input  wire gsau_pkg::vec_t i_sa_array_in,
  input  wire logic           i_sa_input_en,
  input  wire logic           i_sa_weight_en,
  output gsau_pkg::vec_t      o_sa_array_output,
  output logic                o_out_en,
  output logic                o_busy
);

  localparam int LANES  = gsau_pkg::LANES;
  localparam int LANE_W = gsau_pkg::LANE_W;

  // weights[i][j] with row i feeding output lane i
  gsau_pkg::lane_t weights [LANES][LANES];

  // next row to load
  logic [gsau_pkg::ROW_W-1:0] row_ptr;

  // stage registers
  // operand copy only needed up to the second to last stage
  logic [LANES-1:0] stg_valid;
  gsau_pkg::vec_t   stg_x   [LANES-1];
  gsau_pkg::vec_t   stg_acc [LANES];

  // stage inputs and next accumulators
  logic [LANES-1:0] v_in;
  gsau_pkg::vec_t   x_in    [LANES];
  gsau_pkg::vec_t   acc_in  [LANES];
  gsau_pkg::vec_t   acc_nxt [LANES];

  // weight row write at the pointer
  always_ff @(posedge CLK) begin
    if (i_sa_weight_en) begin
      for (int j = 0; j < LANES; j++) begin
        weights[row_ptr][j] <= i_sa_array_in[j*LANE_W +: LANE_W];
      end
    end
  end

  // pointer wraps after the last row
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      row_ptr <= '0;
    end else if (i_sa_weight_en) begin
      row_ptr <= row_ptr + 1'b1;
    end
  end

  // stage 0 takes the new operand with a zero sum
  always_comb begin
    v_in[0]   = i_sa_input_en;
    x_in[0]   = i_sa_array_in;
    acc_in[0] = '0;
    for (int j = 1; j < LANES; j++) begin
      v_in[j]   = stg_valid[j-1];
      x_in[j]   = stg_x[j-1];
      acc_in[j] = stg_acc[j-1];
    end
  end

  // stage j adds W[i][j] * x[j] of column j into lane i
  // 16-bit context wraps product and sum
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      for (int i = 0; i < LANES; i++) begin
        acc_nxt[j][i*LANE_W +: LANE_W] = acc_in[j][i*LANE_W +: LANE_W]
                                       + weights[i][j] * x_in[j][j*LANE_W +: LANE_W];
      end
    end
  end

  // valid bits advance every cycle
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      stg_valid <= '0;
    end else begin
      stg_valid <= v_in;
    end
  end

  // operand and partial sums run free
  always_ff @(posedge CLK) begin
    for (int j = 0; j < LANES; j++) begin
      stg_acc[j] <= acc_nxt[j];
    end
    for (int j = 0; j < LANES - 1; j++) begin
      stg_x[j] <= x_in[j];
    end
  end

  // last stage holds the finished product
  assign o_sa_array_output = stg_acc[LANES-1];
  assign o_out_en          = stg_valid[LANES-1];

  // anything still in the pipe
  assign o_busy = |stg_valid;

endmodule

`default_nettype wire

// File: src/gsau_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_writeback (
  input  wire logic            CLK,
  input  wire logic            nRST,
  // array result
  input  wire logic            i_out_en,
  input  wire gsau_pkg::vec_t  i_sa_array_output,
  // destination fifo head
  input  wire gsau_pkg::vdst_t i_dest_head,
  output logic                 o_dest_pop,
  // writeback buffer
  input  wire logic            i_wb_ready,
  output gsau_pkg::vec_t       o_wb_psum,
  output gsau_pkg::vdst_t      o_wb_wbdst,
  output logic                 o_wb_valid
);

  logic res_empty;
  logic xfer;

  // result queue, same depth as the destination fifo
  // outstanding inputs are capped there, so no overflow
  gsau_fifo #(
    .WIDTH ($bits(gsau_pkg::vec_t)),
    .DEPTH (gsau_pkg::DEST_DEPTH)
  ) u_res_fifo (
    .CLK    (CLK),
    .nRST   (nRST),
    .i_wr   (i_out_en),
    .i_rd   (xfer),
    .i_din  (i_sa_array_output),
    .o_dout (o_wb_psum),
    .o_empty(res_empty),
    .o_full ()
  );

  // queued result pairs with the oldest destination
  // both fifos fill in acceptance order
  assign o_wb_valid = !res_empty;
  assign o_wb_wbdst = i_dest_head;

  // transfer on the edge with ready high
  assign xfer = o_wb_valid && i_wb_ready;

  // free the destination slot with the result
  assign o_dest_pop = xfer;

endmodule

`default_nettype wire

// File: src/gsau_top.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_top (
  input  wire logic            CLK,
  input  wire logic            nRST,
  // scoreboard
  input  wire logic            i_sb_nvalid,
  input  wire gsau_pkg::vdst_t i_sb_nvdst,
  input  wire logic            i_sb_weight,
  // vector register file
  input  wire logic            i_veg_valid,
  input  wire gsau_pkg::vec_t  i_veg_vdata,
  // writeback buffer
  input  wire logic            i_wb_ready,
  // ready levels
  output logic                 o_sb_ready,
  output logic                 o_veg_ready,
  // scoreboard notification
  output logic                 o_sb_valid,
  output gsau_pkg::vdst_t      o_sb_vdst,
  // writeback
  output gsau_pkg::vec_t       o_wb_psum,
  output gsau_pkg::vdst_t      o_wb_wbdst,
  output logic                 o_wb_valid
);

  // issue to array
  gsau_pkg::vec_t  sa_array_in;
  logic            sa_input_en;
  logic            sa_weight_en;

  // array to issue and writeback
  gsau_pkg::vec_t  sa_array_output;
  logic            sa_out_en;
  logic            sa_busy;

  // destination fifo
  logic            dest_push;
  logic            dest_pop;
  logic            dest_full;
  gsau_pkg::vdst_t dest_din;
  gsau_pkg::vdst_t dest_head;

  gsau_issue u_issue (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_sb_nvalid   (i_sb_nvalid),
    .i_sb_nvdst    (i_sb_nvdst),
    .i_sb_weight   (i_sb_weight),
    .i_veg_valid   (i_veg_valid),
    .i_veg_vdata   (i_veg_vdata),
    .i_dest_full   (dest_full),
    .i_busy        (sa_busy),
    .o_sb_ready    (o_sb_ready),
    .o_veg_ready   (o_veg_ready),
    .o_sb_valid    (o_sb_valid),
    .o_sb_vdst     (o_sb_vdst),
    .o_sa_array_in (sa_array_in),
    .o_sa_input_en (sa_input_en),
    .o_sa_weight_en(sa_weight_en),
    .o_dest_push   (dest_push),
    .o_dest_din    (dest_din)
  );

  // one slot per outstanding input
  // full here is what throttles the scoreboard
  gsau_fifo #(
    .WIDTH (gsau_pkg::VDST_W),
    .DEPTH (gsau_pkg::DEST_DEPTH)
  ) u_dest_fifo (
    .CLK    (CLK),
    .nRST   (nRST),
    .i_wr   (dest_push),
    .i_rd   (dest_pop),
    .i_din  (dest_din),
    .o_dout (dest_head),
    .o_empty(),
    .o_full (dest_full)
  );

  gsau_array u_array (
    .CLK              (CLK),
    .nRST             (nRST),
    .i_sa_array_in    (sa_array_in),
    .i_sa_input_en    (sa_input_en),
    .i_sa_weight_en   (sa_weight_en),
    .o_sa_array_output(sa_array_output),
    .o_out_en         (sa_out_en),
    .o_busy           (sa_busy)
  );

  gsau_writeback u_writeback (
    .CLK              (CLK),
    .nRST             (nRST),
    .i_out_en         (sa_out_en),
    .i_sa_array_output(sa_array_output),
    .i_dest_head      (dest_head),
    .o_dest_pop       (dest_pop),
    .i_wb_ready       (i_wb_ready),
    .o_wb_psum        (o_wb_psum),
    .o_wb_wbdst       (o_wb_wbdst),
    .o_wb_valid       (o_wb_valid)
  );

endmodule

`default_nettype wire

// File: tb/gsau_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gsau_tb;

  localparam int LANES       = gsau_pkg::LANES;
  localparam int LANE_W      = gsau_pkg::LANE_W;
  localparam int NUM_ENTRIES = 26;
  // i_wb_ready modes
  localparam int RDY_RANDOM  = 0;
  localparam int RDY_HIGH    = 1;
  localparam int RDY_LOW     = 2;

  logic            CLK;
  logic            nRST;
  logic            i_sb_nvalid;
  gsau_pkg::vdst_t i_sb_nvdst;
  logic            i_sb_weight;
  logic            i_veg_valid;
  gsau_pkg::vec_t  i_veg_vdata;
  logic            i_wb_ready;
  logic            o_sb_ready;
  logic            o_veg_ready;
  logic            o_sb_valid;
  gsau_pkg::vdst_t o_sb_vdst;
  gsau_pkg::vec_t  o_wb_psum;
  gsau_pkg::vdst_t o_wb_wbdst;
  logic            o_wb_valid;

  // instruction table, one column per field
  logic            tbl_weight [NUM_ENTRIES];
  gsau_pkg::vdst_t tbl_dest   [NUM_ENTRIES];
  gsau_pkg::vec_t  tbl_data   [NUM_ENTRIES];
  int              tbl_hold   [NUM_ENTRIES];

  // reference model
  gsau_pkg::lane_t w_model [LANES][LANES];
  int              row_m = 0;
  // one bit per input still in the array
  logic [LANES-1:0] busy_sh = '0;
  // results sitting in the writeback queue
  int              avail_cnt = 0;
  logic            acc_last = 1'b0;
  logic            acc_now;
  logic            xfer_now;
  logic            exp_sb_ready;
  logic            exp_veg_ready;
  gsau_pkg::vec_t  exp_psum_q [$];
  gsau_pkg::vdst_t exp_dest_q [$];
  gsau_pkg::vdst_t notify_q   [$];

  int              seed;
  int              rdy_mode;
  logic [31:0]     rnd_word;
  logic            accept_w;

  gsau_top dut (
    .CLK        (CLK),
    .nRST       (nRST),
    .i_sb_nvalid(i_sb_nvalid),
    .i_sb_nvdst (i_sb_nvdst),
    .i_sb_weight(i_sb_weight),
    .i_veg_valid(i_veg_valid),
    .i_veg_vdata(i_veg_vdata),
    .i_wb_ready (i_wb_ready),
    .o_sb_ready (o_sb_ready),
    .o_veg_ready(o_veg_ready),
    .o_sb_valid (o_sb_valid),
    .o_sb_vdst  (o_sb_vdst),
    .o_wb_psum  (o_wb_psum),
    .o_wb_wbdst (o_wb_wbdst),
    .o_wb_valid (o_wb_valid)
  );

  // instruction taken on the coming edge
  assign accept_w = i_sb_nvalid && i_veg_valid && o_sb_ready && o_veg_ready;

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // W times x row by row, every product and sum wraps at 16 bits
  function automatic gsau_pkg::vec_t mat_vec(input gsau_pkg::vec_t x);
    gsau_pkg::vec_t  r;
    gsau_pkg::lane_t s;
    int              i;
    int              j;
    r = '0;
    for (i = 0; i < LANES; i++) begin
      s = '0;
      for (j = 0; j < LANES; j++) begin
        s = s + w_model[i][j] * x[j*LANE_W +: LANE_W];
      end
      r[i*LANE_W +: LANE_W] = s;
    end
    return r;
  endfunction

  // next row of the model matrix, pointer wraps
  task automatic load_row(input gsau_pkg::vec_t x);
    int j;
    for (j = 0; j < LANES; j++) begin
      w_model[row_m][j] = x[j*LANE_W +: LANE_W];
    end
    row_m = (row_m + 1) % LANES;
  endtask

  task automatic set_entry(input int k, input logic w, input gsau_pkg::vdst_t d,
                           input gsau_pkg::vec_t x, input int h);
    tbl_weight[k] = w;
    tbl_dest[k]   = d;
    tbl_data[k]   = x;
    tbl_hold[k]   = h;
  endtask

  task automatic build_table();
    int k;
    // four weight rows, signed mix incl. extremes
    set_entry(0, 1'b1, 8'hf0, {16'h0004, 16'hfffd, 16'h0002, 16'h0001}, 0);
    set_entry(1, 1'b1, 8'hf1, {16'hfffe, 16'h0007, 16'h0005, 16'hffff}, 1);
    set_entry(2, 1'b1, 8'hf2, {16'h0001, 16'h0003, 16'h8000, 16'h7fff}, 0);
    set_entry(3, 1'b1, 8'hf3, {16'h000b, 16'h0009, 16'h0000, 16'hfff9}, 2);
    // random operands, uneven gaps
    for (k = 4; k < 12; k++) begin
      set_entry(k, 1'b0, 8'(k + 32), {$random(seed), $random(seed)}, k % 3);
    end
    // lone input for the latency check
    set_entry(12, 1'b0, 8'h40, {$random(seed), $random(seed)}, 0);
    // back to back, enough to fill the destination fifo
    for (k = 13; k < 21; k++) begin
      set_entry(k, 1'b0, 8'(k + 64), {$random(seed), $random(seed)}, 0);
    end
    set_entry(21, 1'b0, 8'h61, {$random(seed), $random(seed)}, 0);
    set_entry(22, 1'b0, 8'h62, {$random(seed), $random(seed)}, 0);
    // new row 0 right behind two inputs in flight
    set_entry(23, 1'b1, 8'hf4, {16'h1234, 16'hff00, 16'h0100, 16'hffff}, 0);
    for (k = 24; k < NUM_ENTRIES; k++) begin
      set_entry(k, 1'b0, 8'(k + 96), {$random(seed), $random(seed)}, k % 2);
    end
  endtask

  // present entry k and hold it until taken, counts stalled cycles
  task automatic send_entry(input int k, output int waited);
    if (tbl_hold[k] > 0) begin
      @(posedge CLK);
      i_sb_nvalid <= 1'b0;
      i_veg_valid <= 1'b0;
      repeat (tbl_hold[k] - 1) @(posedge CLK);
    end
    @(posedge CLK);
    i_sb_nvalid <= 1'b1;
    i_veg_valid <= 1'b1;
    i_sb_weight <= tbl_weight[k];
    i_sb_nvdst  <= tbl_dest[k];
    i_veg_vdata <= tbl_data[k];
    waited = 0;
    @(negedge CLK);
    while (!accept_w) begin
      waited++;
      @(negedge CLK);
    end
  endtask

  task automatic run_range(input int lo, input int hi);
    int waited;
    int k;
    for (k = lo; k < hi; k++) begin
      send_entry(k, waited);
    end
  endtask

  task automatic idle_bus();
    @(posedge CLK);
    i_sb_nvalid <= 1'b0;
    i_veg_valid <= 1'b0;
  endtask

  // every accepted input written back
  task automatic drain_results();
    while (exp_psum_q.size() > 0) @(negedge CLK);
  endtask

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // writeback buffer ready level
  initial begin
    i_wb_ready = 1'b0;
    forever begin
      @(posedge CLK);
      rnd_word = $random(seed);
      case (rdy_mode)
        RDY_HIGH: i_wb_ready <= 1'b1;
        RDY_LOW:  i_wb_ready <= 1'b0;
        default:  i_wb_ready <= rnd_word[0];
      endcase
    end
  end

  initial begin
    repeat (NUM_ENTRIES * 40) @(posedge CLK);
    $display("run timed out after %0d clock cycles", NUM_ENTRIES * 40);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // sampled mid-cycle, events below happen on the next rising edge
  always @(negedge CLK) begin
    if (nRST) begin
      exp_sb_ready  = (exp_psum_q.size() < gsau_pkg::DEST_DEPTH);
      exp_veg_ready = exp_sb_ready && (!i_sb_weight || busy_sh == '0);
      check_val("o_sb_ready", 64'(o_sb_ready), 64'(exp_sb_ready));
      check_val("o_veg_ready", 64'(o_veg_ready), 64'(exp_veg_ready));
      check_val("o_wb_valid", 64'(o_wb_valid), 64'(avail_cnt > 0));
      check_val("o_sb_valid", 64'(o_sb_valid), 64'(acc_last));
      if (o_sb_valid) begin
        check_val("o_sb_vdst", 64'(o_sb_vdst), 64'(notify_q[0]));
        notify_q.delete(0);
      end
      xfer_now = o_wb_valid && i_wb_ready;
      if (xfer_now) begin
        check_val("o_wb_psum", o_wb_psum, exp_psum_q[0]);
        check_val("o_wb_wbdst", 64'(o_wb_wbdst), 64'(exp_dest_q[0]));
        exp_psum_q.delete(0);
        exp_dest_q.delete(0);
      end
      acc_now = accept_w;
      if (acc_now) begin
        notify_q.push_back(i_sb_nvdst);
        if (i_sb_weight) begin
          load_row(i_veg_vdata);
        end else begin
          exp_psum_q.push_back(mat_vec(i_veg_vdata));
          exp_dest_q.push_back(i_sb_nvdst);
        end
      end
      // oldest array entry lands in the queue
      if (busy_sh[LANES-1]) avail_cnt++;
      if (xfer_now) avail_cnt--;
      busy_sh  = {busy_sh[LANES-2:0], acc_now && !i_sb_weight};
      acc_last = acc_now;
    end
  end

  initial begin
    int waited;
    int lat;
    seed        = 32'h37c3_4003;
    rdy_mode    = RDY_RANDOM;
    nRST        = 1'b0;
    i_sb_nvalid = 1'b0;
    i_sb_nvdst  = '0;
    i_sb_weight = 1'b0;
    i_veg_valid = 1'b0;
    i_veg_vdata = '0;
    build_table();
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;

    // idle levels out of reset
    @(negedge CLK);
    check_val("o_wb_valid", 64'(o_wb_valid), 64'd0);
    check_val("o_sb_valid", 64'(o_sb_valid), 64'd0);
    check_val("o_sb_ready", 64'(o_sb_ready), 64'd1);
    check_val("o_veg_ready", 64'(o_veg_ready), 64'd1);

    // weights, then inputs under random back-pressure
    run_range(0, 12);
    idle_bus();
    drain_results();

    // empty queue, ready high, accept to valid is 5 edges
    rdy_mode = RDY_HIGH;
    send_entry(12, waited);
    idle_bus();
    lat = 0;
    do begin
      @(negedge CLK);
      lat++;
    end while (!o_wb_valid && lat < 20);
    check_val("o_wb_valid latency", 64'(lat), 64'd5);
    drain_results();

    // stalled writeback fills the destination fifo
    rdy_mode = RDY_LOW;
    run_range(13, 21);
    idle_bus();
    @(negedge CLK);
    check_val("o_sb_ready", 64'(o_sb_ready), 64'd0);
    check_val("o_veg_ready", 64'(o_veg_ready), 64'd0);
    repeat (2 * LANES) @(negedge CLK);
    rdy_mode = RDY_HIGH;
    drain_results();

    // weight load waits out the 4 busy stages
    rdy_mode = RDY_RANDOM;
    run_range(21, 23);
    send_entry(23, waited);
    check_val("weight stall cycles", 64'(waited), 64'(LANES));
    run_range(24, NUM_ENTRIES);
    idle_bus();
    drain_results();
    repeat (2) @(negedge CLK);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/gsau_pkg.sv
src/gsau_fifo.sv
src/gsau_issue.sv
src/gsau_array.sv
src/gsau_writeback.sv
src/gsau_top.sv
tb/gsau_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := gsau_tb
FLIST     := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
